// File: verilog/radio_pkg.sv
`default_nettype none

package radio_pkg;

   // One word of the 64-bit packet stream
   typedef logic [63:0] word_t;

   // Stream word together with its end-of-packet flag
   typedef struct packed {
      logic  last;
      word_t data;
   } beat_t;

   typedef logic [11:0] seqnum_t;
   typedef logic [31:0] sid_t;

   // What a transmit acknowledgement needs to carry
   typedef struct packed {
      seqnum_t seqnum;
      sid_t    sid;
   } ack_info_t;

   // Routing by SID bits 1 to 0
   typedef enum logic [1:0] {
      ROUTE_TX    = 2'd0,
      ROUTE_CTRL  = 2'd1,
      ROUTE_RXFC  = 2'd2,
      ROUTE_RXCMD = 2'd3
   } route_e;

   // Packet type codes in header bits 63 to 60
   localparam logic [3:0] PKT_TYPE_RESP = 4'hE;
   localparam logic [3:0] PKT_TYPE_ACK  = 4'h1;

   // Sequence number field starts here in the header
   localparam int SEQ_LSB = 48;

endpackage

`default_nettype wire

// File: verilog/radio_regs_pkg.sv
`default_nettype none

package radio_regs_pkg;

   typedef logic [7:0] set_addr_t;

   // Setting addresses
   localparam set_addr_t SR_TEST      = 8'd7;
   localparam set_addr_t SR_MISC_OUTS = 8'd24;
   localparam set_addr_t SR_READBACK  = 8'd32;

   // Readback selects above RB_RADIO_NUM read as zero
   typedef enum logic [2:0] {
      RB_TEST      = 3'd0,
      RB_MISC_OUTS = 3'd1,
      RB_MISC_INS  = 3'd2,
      RB_RADIO_NUM = 3'd3
   } rb_sel_e;

endpackage

`default_nettype wire

// File: verilog/sid_demux.sv
`default_nettype none

module sid_demux
   import radio_pkg::*;
(
   input  wire   bus_clk,
   input  wire   bus_rst,
   input  word_t i_in_tdata,
   input  wire   i_in_tlast,
   input  wire   i_in_tvalid,
   output logic  o_in_tready,
   output word_t o_tx_tdata,
   output logic  o_tx_tlast,
   output logic  o_tx_tvalid,
   input  wire   i_tx_tready,
   output word_t o_ctrl_tdata,
   output logic  o_ctrl_tlast,
   output logic  o_ctrl_tvalid,
   input  wire   i_ctrl_tready
);

   logic   first;
   route_e route_q;
   route_e route;

   // Header word picks the route, later words follow the stored one
   assign route = first ? route_e'(i_in_tdata[1:0]) : route_q;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         first   <= 1'b1;
         route_q <= ROUTE_TX;
      end else if (i_in_tvalid && o_in_tready) begin
         first <= i_in_tlast;
         if (first)
            route_q <= route;
      end
   end

   assign o_tx_tdata   = i_in_tdata;
   assign o_tx_tlast   = i_in_tlast;
   assign o_tx_tvalid  = i_in_tvalid && (route == ROUTE_TX);

   assign o_ctrl_tdata  = i_in_tdata;
   assign o_ctrl_tlast  = i_in_tlast;
   assign o_ctrl_tvalid = i_in_tvalid && (route == ROUTE_CTRL);

   // RX flow control and RX commands have no sink here
   always_comb begin
      case (route)
         ROUTE_TX:    o_in_tready = i_tx_tready;
         ROUTE_CTRL:  o_in_tready = i_ctrl_tready;
         ROUTE_RXFC:  o_in_tready = 1'b1;
         ROUTE_RXCMD: o_in_tready = 1'b1;
         default:     o_in_tready = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
`default_nettype none

module stream_fifo #(
   parameter type T          = logic [63:0],
   parameter int  DEPTH_LOG2 = 2
) (
   input  wire  bus_clk,
   input  wire  bus_rst,
   input  T     i_data,
   input  wire  i_valid,
   output logic o_ready,
   output T     o_data,
   output logic o_valid,
   input  wire  i_ready
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   T mem [DEPTH];

   // Extra pointer bit tells full from empty
   logic [DEPTH_LOG2:0] wr_ptr;
   logic [DEPTH_LOG2:0] rd_ptr;
   logic                full;
   logic                empty;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

   assign o_ready = !full;
   assign o_valid = !empty;
   assign o_data  = mem[rd_ptr[DEPTH_LOG2-1:0]];

   always_ff @(posedge bus_clk) begin
      if (i_valid && o_ready)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
   end

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (i_valid && o_ready)
            wr_ptr <= wr_ptr + 1'b1;
         if (o_valid && i_ready)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/ctrl_proc.sv
`default_nettype none

module ctrl_proc
   import radio_pkg::*;
   import radio_regs_pkg::*;
(
   input  wire         bus_clk,
   input  wire         bus_rst,
   input  word_t       i_ctrl_tdata,
   input  wire         i_ctrl_tlast,
   input  wire         i_ctrl_tvalid,
   output logic        o_ctrl_tready,
   output word_t       o_resp_tdata,
   output logic        o_resp_tlast,
   output logic        o_resp_tvalid,
   input  wire         i_resp_tready,
   output logic        o_set_stb,
   output set_addr_t   o_set_addr,
   output logic [31:0] o_set_data,
   input  word_t       i_rb_data
);

   typedef enum logic [2:0] {
      ST_HDR,
      ST_SET,
      ST_RESP_HDR,
      ST_RESP_DATA,
      ST_DRAIN
   } state_e;

   state_e state;
   word_t  hdr_q;
   word_t  rb_q;
   logic   more_q;
   logic   rb_held;
   logic   ctrl_fire;

   assign ctrl_fire     = i_ctrl_tvalid && o_ctrl_tready;
   assign o_ctrl_tready = (state == ST_HDR) || (state == ST_SET) || (state == ST_DRAIN);
   assign o_resp_tvalid = (state == ST_RESP_HDR) || (state == ST_RESP_DATA);
   assign o_resp_tlast  = (state == ST_RESP_DATA);

   // Readback is live on the first data cycle, then frozen until taken
   always_comb begin
      if (state == ST_RESP_HDR)
         o_resp_tdata = {PKT_TYPE_RESP, hdr_q[59:0]};
      else if (rb_held)
         o_resp_tdata = rb_q;
      else
         o_resp_tdata = i_rb_data;
   end

   //////////////////////////////////////////
   // Packet FSM
   //////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state     <= ST_HDR;
         o_set_stb <= 1'b0;
         more_q    <= 1'b0;
         rb_held   <= 1'b0;
      end else begin
         o_set_stb <= 1'b0;
         case (state)
            // A header-only packet is dropped without a response
            ST_HDR: begin
               if (ctrl_fire && !i_ctrl_tlast)
                  state <= ST_SET;
            end
            ST_SET: begin
               if (ctrl_fire) begin
                  o_set_stb <= 1'b1;
                  more_q    <= !i_ctrl_tlast;
                  state     <= ST_RESP_HDR;
               end
            end
            ST_RESP_HDR: begin
               if (i_resp_tready)
                  state <= ST_RESP_DATA;
            end
            ST_RESP_DATA: begin
               rb_held <= 1'b1;
               if (i_resp_tready) begin
                  rb_held <= 1'b0;
                  state   <= more_q ? ST_DRAIN : ST_HDR;
               end
            end
            ST_DRAIN: begin
               if (ctrl_fire && i_ctrl_tlast)
                  state <= ST_HDR;
            end
            default: state <= ST_HDR;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if (state == ST_HDR && ctrl_fire)
         hdr_q <= i_ctrl_tdata;
      if (state == ST_SET && ctrl_fire) begin
         o_set_addr <= i_ctrl_tdata[39:32];
         o_set_data <= i_ctrl_tdata[31:0];
      end
      if (state == ST_RESP_DATA && !rb_held)
         rb_q <= i_rb_data;
   end

endmodule

`default_nettype wire

// File: verilog/setting_regs.sv
`default_nettype none

module setting_regs
   import radio_pkg::*;
   import radio_regs_pkg::*;
#(
   parameter int RADIO_NUM = 0
) (
   input  wire         bus_clk,
   input  wire         bus_rst,
   input  wire         i_set_stb,
   input  set_addr_t   i_set_addr,
   input  wire  [31:0] i_set_data,
   input  wire  [31:0] i_misc_ins,
   output logic [31:0] o_misc_outs,
   output word_t       o_rb_data
);

   logic [31:0] test_q;
   logic [31:0] misc_q;
   rb_sel_e     rb_sel_q;

   //////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         test_q   <= '0;
         misc_q   <= '0;
         rb_sel_q <= RB_TEST;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_TEST:      test_q   <= i_set_data;
            SR_MISC_OUTS: misc_q   <= i_set_data;
            SR_READBACK:  rb_sel_q <= rb_sel_e'(i_set_data[2:0]);
            default:      ;
         endcase
      end
   end

   assign o_misc_outs = misc_q;

   //////////////////////////////////////////
   // Readback mux
   //////////////////////////////////////////

   always_comb begin
      case (rb_sel_q)
         RB_TEST:      o_rb_data = {32'd0, test_q};
         RB_MISC_OUTS: o_rb_data = {32'd0, misc_q};
         RB_MISC_INS:  o_rb_data = {32'd0, i_misc_ins};
         RB_RADIO_NUM: o_rb_data = {32'd0, 32'(RADIO_NUM)};
         // Unused selects read back as zero
         default:      o_rb_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/tx_ack_gen.sv
`default_nettype none

module tx_ack_gen
   import radio_pkg::*;
#(
   parameter int DATA_FIFO_LOG2 = 4
) (
   input  wire   bus_clk,
   input  wire   bus_rst,
   input  word_t i_tx_tdata,
   input  wire   i_tx_tlast,
   input  wire   i_tx_tvalid,
   output logic  o_tx_tready,
   output word_t o_port_tdata,
   output logic  o_port_tlast,
   output logic  o_port_tvalid,
   input  wire   i_port_tready,
   output word_t o_ack_tdata,
   output logic  o_ack_tlast,
   output logic  o_ack_tvalid,
   input  wire   i_ack_tready
);

   localparam int ACK_FIFO_LOG2 = 2;

   beat_t     in_beat;
   beat_t     out_beat;
   logic      data_valid;
   logic      data_pop;
   logic      ack_space;
   logic      port_fire;
   logic      first;
   seqnum_t   seq_q;
   sid_t      sid_q;
   ack_info_t ack_in;
   ack_info_t ack_out;

   assign in_beat = '{last: i_tx_tlast, data: i_tx_tdata};

   stream_fifo #(.T(beat_t), .DEPTH_LOG2(DATA_FIFO_LOG2)) data_fifo_i (
      .bus_clk (bus_clk),
      .bus_rst (bus_rst),
      .i_data  (in_beat),
      .i_valid (i_tx_tvalid),
      .o_ready (o_tx_tready),
      .o_data  (out_beat),
      .o_valid (data_valid),
      .i_ready (data_pop)
   );

   // Port stalls while the ack queue has no room
   assign o_port_tvalid = data_valid && ack_space;
   assign o_port_tdata  = out_beat.data;
   assign o_port_tlast  = out_beat.last;
   assign data_pop      = i_port_tready && ack_space;
   assign port_fire     = o_port_tvalid && i_port_tready;

   always_ff @(posedge bus_clk) begin
      if (bus_rst)
         first <= 1'b1;
      else if (port_fire)
         first <= out_beat.last;
   end

   always_ff @(posedge bus_clk) begin
      if (port_fire && first) begin
         seq_q <= out_beat.data[SEQ_LSB +: $bits(seqnum_t)];
         sid_q <= out_beat.data[31:0];
      end
   end

   // One-word packets take their info straight from the header
   always_comb begin
      if (first) begin
         ack_in.seqnum = out_beat.data[SEQ_LSB +: $bits(seqnum_t)];
         ack_in.sid    = out_beat.data[31:0];
      end else begin
         ack_in.seqnum = seq_q;
         ack_in.sid    = sid_q;
      end
   end

   stream_fifo #(.T(ack_info_t), .DEPTH_LOG2(ACK_FIFO_LOG2)) ack_fifo_i (
      .bus_clk (bus_clk),
      .bus_rst (bus_rst),
      .i_data  (ack_in),
      .i_valid (port_fire && out_beat.last),
      .o_ready (ack_space),
      .o_data  (ack_out),
      .o_valid (o_ack_tvalid),
      .i_ready (i_ack_tready)
   );

   assign o_ack_tdata = {PKT_TYPE_ACK, ack_out.seqnum, 16'd0, ack_out.sid};
   assign o_ack_tlast = 1'b1;

endmodule

`default_nettype wire

// File: verilog/out_mux.sv
`default_nettype none

module out_mux
   import radio_pkg::*;
(
   input  wire   bus_clk,
   input  wire   bus_rst,
   input  word_t i_resp_tdata,
   input  wire   i_resp_tlast,
   input  wire   i_resp_tvalid,
   output logic  o_resp_tready,
   input  word_t i_ack_tdata,
   input  wire   i_ack_tlast,
   input  wire   i_ack_tvalid,
   output logic  o_ack_tready,
   output word_t o_out_tdata,
   output logic  o_out_tlast,
   output logic  o_out_tvalid,
   input  wire   i_out_tready
);

   // Source 0 is the response path, source 1 the ack path
   logic  pick;
   logic  sel_q;
   logic  locked;
   logic  rr_q;
   logic  src_valid;
   word_t src_data;
   logic  src_last;
   logic  can_load;
   logic  take;

   always_comb begin
      if (locked)
         pick = sel_q;
      else if (rr_q ? i_ack_tvalid : i_resp_tvalid)
         pick = rr_q;
      else
         pick = !rr_q;
   end

   assign src_valid = pick ? i_ack_tvalid : i_resp_tvalid;
   assign src_data  = pick ? i_ack_tdata  : i_resp_tdata;
   assign src_last  = pick ? i_ack_tlast  : i_resp_tlast;

   // Output register refills when empty or being drained
   assign can_load      = !o_out_tvalid || i_out_tready;
   assign take          = can_load && src_valid;
   assign o_resp_tready = can_load && !pick;
   assign o_ack_tready  = can_load && pick;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         locked <= 1'b0;
         sel_q  <= 1'b0;
         rr_q   <= 1'b0;
      end else if (take) begin
         if (src_last) begin
            locked <= 1'b0;
            rr_q   <= !pick;
         end else begin
            locked <= 1'b1;
            sel_q  <= pick;
         end
      end
   end

   always_ff @(posedge bus_clk) begin
      if (bus_rst)
         o_out_tvalid <= 1'b0;
      else if (can_load)
         o_out_tvalid <= src_valid;
   end

   always_ff @(posedge bus_clk) begin
      if (take) begin
         o_out_tdata <= src_data;
         o_out_tlast <= src_last;
      end
   end

endmodule

`default_nettype wire

// File: verilog/radio_core.sv
`default_nettype none

module radio_core
   import radio_pkg::*;
   import radio_regs_pkg::*;
#(
   parameter int RADIO_NUM      = 0,
   parameter int DATA_FIFO_LOG2 = 4
) (
   input  wire         bus_clk,
   input  wire         bus_rst,
   input  word_t       i_in_tdata,
   input  wire         i_in_tlast,
   input  wire         i_in_tvalid,
   output logic        o_in_tready,
   output word_t       o_out_tdata,
   output logic        o_out_tlast,
   output logic        o_out_tvalid,
   input  wire         i_out_tready,
   output word_t       o_tx_tdata,
   output logic        o_tx_tlast,
   output logic        o_tx_tvalid,
   input  wire         i_tx_tready,
   input  wire  [31:0] i_misc_ins,
   output logic [31:0] o_misc_outs
);

   word_t       tx_tdata;
   logic        tx_tlast, tx_tvalid, tx_tready;
   word_t       ctrl_tdata;
   logic        ctrl_tlast, ctrl_tvalid, ctrl_tready;
   word_t       resp_tdata;
   logic        resp_tlast, resp_tvalid, resp_tready;
   word_t       ack_tdata;
   logic        ack_tlast, ack_tvalid, ack_tready;
   logic        set_stb;
   set_addr_t   set_addr;
   logic [31:0] set_data;
   word_t       rb_data;

   //////////////////////////////////////////
   // Input side split by SID
   //////////////////////////////////////////

   sid_demux sid_demux_i (
      .bus_clk       (bus_clk),     .bus_rst      (bus_rst),
      .i_in_tdata    (i_in_tdata),  .i_in_tlast   (i_in_tlast),
      .i_in_tvalid   (i_in_tvalid), .o_in_tready  (o_in_tready),
      .o_tx_tdata    (tx_tdata),    .o_tx_tlast   (tx_tlast),
      .o_tx_tvalid   (tx_tvalid),   .i_tx_tready  (tx_tready),
      .o_ctrl_tdata  (ctrl_tdata),  .o_ctrl_tlast (ctrl_tlast),
      .o_ctrl_tvalid (ctrl_tvalid), .i_ctrl_tready(ctrl_tready)
   );

   // Control path and setting registers
   ctrl_proc ctrl_proc_i (
      .bus_clk       (bus_clk),     .bus_rst      (bus_rst),
      .i_ctrl_tdata  (ctrl_tdata),  .i_ctrl_tlast (ctrl_tlast),
      .i_ctrl_tvalid (ctrl_tvalid), .o_ctrl_tready(ctrl_tready),
      .o_resp_tdata  (resp_tdata),  .o_resp_tlast (resp_tlast),
      .o_resp_tvalid (resp_tvalid), .i_resp_tready(resp_tready),
      .o_set_stb     (set_stb),     .o_set_addr   (set_addr),
      .o_set_data    (set_data),    .i_rb_data    (rb_data)
   );

   setting_regs #(.RADIO_NUM(RADIO_NUM)) setting_regs_i (
      .bus_clk     (bus_clk),    .bus_rst    (bus_rst),
      .i_set_stb   (set_stb),    .i_set_addr (set_addr),
      .i_set_data  (set_data),   .i_misc_ins (i_misc_ins),
      .o_misc_outs (o_misc_outs), .o_rb_data (rb_data)
   );

   // Transmit data out through the FIFO, acks back toward the host
   tx_ack_gen #(.DATA_FIFO_LOG2(DATA_FIFO_LOG2)) tx_ack_gen_i (
      .bus_clk       (bus_clk),     .bus_rst       (bus_rst),
      .i_tx_tdata    (tx_tdata),    .i_tx_tlast    (tx_tlast),
      .i_tx_tvalid   (tx_tvalid),   .o_tx_tready   (tx_tready),
      .o_port_tdata  (o_tx_tdata),  .o_port_tlast  (o_tx_tlast),
      .o_port_tvalid (o_tx_tvalid), .i_port_tready (i_tx_tready),
      .o_ack_tdata   (ack_tdata),   .o_ack_tlast   (ack_tlast),
      .o_ack_tvalid  (ack_tvalid),  .i_ack_tready  (ack_tready)
   );

   //////////////////////////////////////////
   // Output merge
   //////////////////////////////////////////

   out_mux out_mux_i (
      .bus_clk       (bus_clk),      .bus_rst       (bus_rst),
      .i_resp_tdata  (resp_tdata),   .i_resp_tlast  (resp_tlast),
      .i_resp_tvalid (resp_tvalid),  .o_resp_tready (resp_tready),
      .i_ack_tdata   (ack_tdata),    .i_ack_tlast   (ack_tlast),
      .i_ack_tvalid  (ack_tvalid),   .o_ack_tready  (ack_tready),
      .o_out_tdata   (o_out_tdata),  .o_out_tlast   (o_out_tlast),
      .o_out_tvalid  (o_out_tvalid), .i_out_tready  (i_out_tready)
   );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD = 4
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

// File: verif/radio_core_tb.sv
`default_nettype none

module radio_core_tb
   import radio_pkg::*;
   import radio_regs_pkg::*;
;

   localparam int RADIO_NUM   = 5;
   localparam int N_TX        = 24;
   localparam int MAX_TX_LEN  = 8;
   localparam int TOTAL_WORDS = N_TX * MAX_TX_LEN + 80;
   // Generous budget per word under random valid and ready
   localparam int WATCHDOG    = (TOTAL_WORDS * 24 + 40) * 4;
   localparam logic [31:0] MISC_INS = 32'hA5C3_0F96;

   logic        bus_clk;
   logic        bus_rst;
   logic [63:0] i_in_tdata;
   logic        i_in_tlast;
   logic        i_in_tvalid;
   logic        o_in_tready;
   logic [63:0] o_out_tdata;
   logic        o_out_tlast;
   logic        o_out_tvalid;
   logic        i_out_tready;
   logic [63:0] o_tx_tdata;
   logic        o_tx_tlast;
   logic        o_tx_tvalid;
   logic        i_tx_tready;
   logic [31:0] i_misc_ins;
   logic [31:0] o_misc_outs;

   integer      seed_in  = 32'h8c62_4ecb;
   integer      seed_out = 32'h8c62_4ecb + 1;

   // Expected traffic filled in by the stimulus side
   logic [64:0] exp_tx[$];
   logic [63:0] exp_resp[$];
   logic [63:0] exp_ack[$];
   logic        resp_open;

   // Model of the setting registers
   logic [31:0] model_test;
   logic [31:0] model_misc;
   logic [2:0]  model_sel;
   logic [11:0] seq_cnt;

   tb_clk_gen #(.PERIOD(4)) tb_clk_gen_i (.o_clk(bus_clk));

   radio_core #(.RADIO_NUM(RADIO_NUM), .DATA_FIFO_LOG2(4)) radio_core_i (
      .bus_clk      (bus_clk),      .bus_rst      (bus_rst),
      .i_in_tdata   (i_in_tdata),   .i_in_tlast   (i_in_tlast),
      .i_in_tvalid  (i_in_tvalid),  .o_in_tready  (o_in_tready),
      .o_out_tdata  (o_out_tdata),  .o_out_tlast  (o_out_tlast),
      .o_out_tvalid (o_out_tvalid), .i_out_tready (i_out_tready),
      .o_tx_tdata   (o_tx_tdata),   .o_tx_tlast   (o_tx_tlast),
      .o_tx_tvalid  (o_tx_tvalid),  .i_tx_tready  (i_tx_tready),
      .i_misc_ins   (i_misc_ins),   .o_misc_outs  (o_misc_outs)
   );

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at time %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
         fail_now("value mismatch");
      end
   endtask

   // Readback the register map gives for a select
   function automatic logic [63:0] expected_readback(input logic [2:0] sel);
      case (sel)
         3'd0:    return {32'd0, model_test};
         3'd1:    return {32'd0, model_misc};
         3'd2:    return {32'd0, MISC_INS};
         3'd3:    return {32'd0, 32'd5};
         default: return 64'd0;
      endcase
   endfunction

   //////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////

   task automatic send_word(input logic [63:0] data, input logic last);
      logic done;
      logic held;
      done = 1'b0;
      held = 1'b0;
      // Once raised, valid stays up until the word is taken
      while (!done) begin
         @(negedge bus_clk);
         i_in_tdata  = data;
         i_in_tlast  = last;
         i_in_tvalid = held || (($random(seed_in) & 3) != 0);
         #1;
         held = i_in_tvalid;
         done = i_in_tvalid && o_in_tready;
      end
   endtask

   function automatic logic [63:0] make_header(input logic [1:0] route);
      logic [31:0] r;
      logic [31:0] s;
      r = $random(seed_in);
      s = $random(seed_in);
      seq_cnt = seq_cnt + 12'd1;
      return {r[31:28], seq_cnt, r[15:0], s[31:2], route};
   endfunction

   task automatic send_ctrl(input set_addr_t addr, input logic [31:0] data, input int extra);
      logic [63:0] hdr;
      hdr = make_header(2'd1);
      case (addr)
         SR_TEST:      model_test = data;
         SR_MISC_OUTS: model_misc = data;
         SR_READBACK:  model_sel  = data[2:0];
         default:      ;
      endcase
      exp_resp.push_back({PKT_TYPE_RESP, hdr[59:0]});
      exp_resp.push_back(expected_readback(model_sel));
      send_word(hdr, 1'b0);
      send_word({24'd0, addr, data}, extra == 0);
      for (int i = 0; i < extra; i++)
         send_word({$random(seed_in), $random(seed_in)}, i == extra - 1);
   endtask

   task automatic send_tx(input int len);
      logic [63:0] hdr;
      logic [63:0] w;
      hdr = make_header(2'd0);
      exp_ack.push_back({PKT_TYPE_ACK, hdr[59:48], 16'd0, hdr[31:0]});
      exp_tx.push_back({len == 1, hdr});
      send_word(hdr, len == 1);
      for (int i = 1; i < len; i++) begin
         w = {$random(seed_in), $random(seed_in)};
         exp_tx.push_back({i == len - 1, w});
         send_word(w, i == len - 1);
      end
   endtask

   // Routes 2 and 3 and header-only control produce nothing
   task automatic send_silent(input logic [1:0] route, input int len);
      send_word(make_header(route), len == 1);
      for (int i = 1; i < len; i++)
         send_word({$random(seed_in), $random(seed_in)}, i == len - 1);
   endtask

   task automatic wait_drained();
      @(negedge bus_clk);
      i_in_tvalid = 1'b0;
      while (exp_tx.size() != 0 || exp_resp.size() != 0 || exp_ack.size() != 0)
         @(negedge bus_clk);
      repeat (20) @(negedge bus_clk);
   endtask

   //////////////////////////////////////////
   // Output compare
   //////////////////////////////////////////

   task automatic compare_tx();
      logic [64:0] e;
      if (exp_tx.size() == 0) begin
         fail_now("transmit port sent a word that was not expected");
      end else begin
         e = exp_tx.pop_front();
         check_value("o_tx_tdata", o_tx_tdata, e[63:0]);
         check_value("o_tx_tlast", {63'd0, o_tx_tlast}, {63'd0, e[64]});
      end
   endtask

   task automatic compare_out();
      if (resp_open) begin
         check_value("o_out_tdata (resp data)", o_out_tdata, exp_resp.pop_front());
         check_value("o_out_tlast (resp data)", {63'd0, o_out_tlast}, 64'd1);
         resp_open = 1'b0;
      end else if (o_out_tdata[63:60] == PKT_TYPE_RESP) begin
         if (exp_resp.size() == 0)
            fail_now("response header on the output with none expected");
         else begin
            check_value("o_out_tdata (resp hdr)", o_out_tdata, exp_resp.pop_front());
            check_value("o_out_tlast (resp hdr)", {63'd0, o_out_tlast}, 64'd0);
            resp_open = 1'b1;
         end
      end else if (o_out_tdata[63:60] == PKT_TYPE_ACK) begin
         if (exp_ack.size() == 0)
            fail_now("acknowledgement on the output with none expected");
         else begin
            check_value("o_out_tdata (ack)", o_out_tdata, exp_ack.pop_front());
            check_value("o_out_tlast (ack)", {63'd0, o_out_tlast}, 64'd1);
         end
      end else begin
         fail_now("output word carries an unknown packet type");
      end
   endtask

   always @(negedge bus_clk) begin
      i_out_tready = (($random(seed_out) & 3) != 0);
      i_tx_tready  = (($random(seed_out) & 1) != 0);
      #1;
      if (!bus_rst) begin
         if (o_tx_tvalid && i_tx_tready)
            compare_tx();
         if (o_out_tvalid && i_out_tready)
            compare_out();
      end
   end

   initial begin
      #(WATCHDOG);
      fail_now("watchdog expired before all traffic finished");
   end

   //////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////

   initial begin
      bus_rst      = 1'b1;
      i_in_tdata   = 64'd0;
      i_in_tlast   = 1'b0;
      i_in_tvalid  = 1'b0;
      i_out_tready = 1'b0;
      i_tx_tready  = 1'b0;
      i_misc_ins   = MISC_INS;
      resp_open    = 1'b0;
      model_test   = 32'd0;
      model_misc   = 32'd0;
      model_sel    = 3'd0;
      seq_cnt      = 12'd0;

      repeat (10) @(negedge bus_clk);
      check_value("o_out_tvalid", {63'd0, o_out_tvalid}, 64'd0);
      check_value("o_tx_tvalid", {63'd0, o_tx_tvalid}, 64'd0);
      check_value("o_misc_outs", {32'd0, o_misc_outs}, 64'd0);
      bus_rst = 1'b0;

      send_ctrl(SR_MISC_OUTS, 32'h1234_5678, 0);
      wait_drained();
      check_value("o_misc_outs", {32'd0, o_misc_outs}, {32'd0, model_misc});

      send_ctrl(SR_TEST, 32'hCAFE_F00D, 0);
      send_ctrl(SR_READBACK, 32'd0, 0);
      send_ctrl(SR_READBACK, 32'd2, 0);
      send_ctrl(SR_READBACK, 32'd3, 0);
      send_ctrl(SR_READBACK, 32'd6, 0);
      send_ctrl(SR_READBACK, 32'd1, 1);

      // Mixed traffic
      for (int n = 0; n < N_TX; n++) begin
         send_tx(1 + ($unsigned($random(seed_in)) % MAX_TX_LEN));
         if (n % 4 == 1)
            send_silent(2'd2, 1 + ($unsigned($random(seed_in)) % 4));
         if (n % 4 == 2)
            send_silent(2'd3, 1 + ($unsigned($random(seed_in)) % 4));
         if (n % 6 == 3)
            send_silent(2'd1, 1);
         if (n % 3 == 0)
            send_ctrl(SR_TEST, $random(seed_in), n % 2);
      end
      send_ctrl(SR_MISC_OUTS, 32'h0BAD_BEEF, 0);
      wait_drained();
      check_value("o_misc_outs", {32'd0, o_misc_outs}, {32'd0, model_misc});

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: radio_core.f
verilog/radio_pkg.sv
verilog/radio_regs_pkg.sv
verilog/sid_demux.sv
verilog/stream_fifo.sv
verilog/ctrl_proc.sv
verilog/setting_regs.sv
verilog/tx_ack_gen.sv
verilog/out_mux.sv
verilog/radio_core.sv
verif/tb_clk_gen.sv
verif/radio_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the radio_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
   -f radio_core.f \
   --top-module radio_core_tb \
   -o radio_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/radio_core_sim
if [ $? -ne 0 ]; then
   echo "Simulation reported failure"
   exit 1
fi

exit 0
